// File: decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// width of a data word and of a program counter.
`define XLEN 32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// width of a register index in an instruction field.
`define REG_AW 5

// number of architectural registers, x0 included.
`define NUM_REGS 32

`endif

// File: decode_pkg.sv
package decode_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // major opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // RV32I base opcodes, bits 6 to 0 of the instruction word.
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_OP_IMM = 7'b0010011,
        OP_OP     = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111
    } opcode_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // immediate format, chosen by the main decoder.
    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_src_t;

    // source of the value written back to rd.
    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_t;

endpackage

// File: decode_stage.sv
`include "decode_defs.svh"

module decode_stage (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    input  logic [`XLEN-1:0]        instr_f_i,
    input  logic [`XLEN-1:0]        pc_f_i,
    input  logic [`XLEN-1:0]        pc_plus_4_f_i,

    input  logic                    stall_d_i,
    input  logic                    flush_d_i,

    input  logic [`REG_AW-1:0]      rd_w_i,
    input  logic [`XLEN-1:0]        result_w_i,
    input  logic                    reg_write_w_i,

    output logic [`XLEN-1:0]        rd1_d_o,
    output logic [`XLEN-1:0]        rd2_d_o,
    output logic [`XLEN-1:0]        imm_ext_d_o,
    output logic [`XLEN-1:0]        pc_d_o,
    output logic [`XLEN-1:0]        pc_plus_4_d_o,
    output logic [`REG_AW-1:0]      rs1_d_o,
    output logic [`REG_AW-1:0]      rs2_d_o,
    output logic [`REG_AW-1:0]      rd_d_o,
    output logic [2:0]              funct3_d_o,
    output logic [6:0]              funct7_d_o,

    output decode_pkg::result_src_t result_src_d_o,
    output logic                    reg_write_d_o,
    output logic                    mem_write_d_o,
    output logic                    alu_src_d_o,
    output logic                    branch_d_o,
    output logic                    jump_d_o,
    output logic                    illegal_d_o
);

    import decode_pkg::*;

    logic [`XLEN-1:0]   instr_d;
    logic [6:0]         op_d;
    imm_src_t           imm_src_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage register and fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    if_id_reg u_if_id_reg (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_d_i),
        .flush_i     (flush_d_i),
        .instr_i     (instr_f_i),
        .pc_i        (pc_f_i),
        .pc_plus_4_i (pc_plus_4_f_i),
        .instr_o     (instr_d),
        .pc_o        (pc_d_o),
        .pc_plus_4_o (pc_plus_4_d_o)
    );

    assign op_d       = instr_d[6:0];
    assign rd_d_o     = instr_d[11:7];
    assign funct3_d_o = instr_d[14:12];
    assign rs1_d_o    = instr_d[19:15];
    assign rs2_d_o    = instr_d[24:20];
    assign funct7_d_o = instr_d[31:25];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode blocks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    reg_file u_reg_file (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .rs1_i     (rs1_d_o),
        .rs2_i     (rs2_d_o),
        .rd_i      (rd_w_i),
        .wr_data_i (result_w_i),
        .wr_en_i   (reg_write_w_i),
        .rd1_o     (rd1_d_o),
        .rd2_o     (rd2_d_o)
    );

    main_decoder u_main_decoder (
        .op_i         (op_d),
        .imm_src_o    (imm_src_d),
        .result_src_o (result_src_d_o),
        .reg_write_o  (reg_write_d_o),
        .mem_write_o  (mem_write_d_o),
        .alu_src_o    (alu_src_d_o),
        .branch_o     (branch_d_o),
        .jump_o       (jump_d_o),
        .illegal_o    (illegal_d_o)
    );

    // the opcode bits carry no immediate, so only bits 31 to 7 go in.
    imm_extend u_imm_extend (
        .instr_i   (instr_d[`XLEN-1:7]),
        .imm_src_i (imm_src_d),
        .imm_ext_o (imm_ext_d_o)
    );

endmodule

// File: if_id_reg.sv
`include "decode_defs.svh"

module if_id_reg (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              flush_i,

    input  logic [`XLEN-1:0]  instr_i,
    input  logic [`XLEN-1:0]  pc_i,
    input  logic [`XLEN-1:0]  pc_plus_4_i,

    output logic [`XLEN-1:0]  instr_o,
    output logic [`XLEN-1:0]  pc_o,
    output logic [`XLEN-1:0]  pc_plus_4_o
);

    logic [`XLEN-1:0] instr_q;
    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] pc_plus_4_q;

    // a cleared word has opcode zero and decodes as a bubble.
    // flush wins over stall so a squashed slot never lingers.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            instr_q     <= '0;
            pc_q        <= '0;
            pc_plus_4_q <= '0;
        end else if (!stall_i) begin
            instr_q     <= instr_i;
            pc_q        <= pc_i;
            pc_plus_4_q <= pc_plus_4_i;
        end
    end

    assign instr_o     = instr_q;
    assign pc_o        = pc_q;
    assign pc_plus_4_o = pc_plus_4_q;

endmodule

// File: imm_extend.sv
`include "decode_defs.svh"

module imm_extend (
    input  logic [`XLEN-1:7]   instr_i,
    input  decode_pkg::imm_src_t imm_src_i,
    output logic [`XLEN-1:0]   imm_ext_o
);

    import decode_pkg::*;

    logic sign;

    assign sign = instr_i[`XLEN-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // format select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        unique case (imm_src_i)
            IMM_I: begin
                imm_ext_o = {{(`XLEN-12){sign}}, instr_i[31:20]};
            end
            IMM_S: begin
                imm_ext_o = {{(`XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            end
            // branch offsets are in half-words, bit 0 is always zero.
            IMM_B: begin
                imm_ext_o = {{(`XLEN-12){sign}}, instr_i[7], instr_i[30:25],
                             instr_i[11:8], 1'b0};
            end
            // upper immediate, low 12 bits are zero filled.
            IMM_U: begin
                imm_ext_o = {instr_i[31:12], 12'b0};
            end
            IMM_J: begin
                imm_ext_o = {{(`XLEN-20){sign}}, instr_i[19:12], instr_i[20],
                             instr_i[30:21], 1'b0};
            end
            default: begin
                imm_ext_o = '0;
            end
        endcase
    end

endmodule

// File: main_decoder.sv
module main_decoder (
    input  logic [6:0]                op_i,

    output decode_pkg::imm_src_t      imm_src_o,
    output decode_pkg::result_src_t   result_src_o,
    output logic                      reg_write_o,
    output logic                      mem_write_o,
    output logic                      alu_src_o,
    output logic                      branch_o,
    output logic                      jump_o,
    output logic                      illegal_o
);

    import decode_pkg::*;

    opcode_t op;

    assign op = opcode_t'(op_i);

    always_comb begin
        // defaults describe a bubble, which is what an unknown opcode gets.
        imm_src_o    = IMM_I;
        result_src_o = RES_ALU;
        reg_write_o  = 1'b0;
        mem_write_o  = 1'b0;
        alu_src_o    = 1'b0;
        branch_o     = 1'b0;
        jump_o       = 1'b0;
        illegal_o    = 1'b0;

        case (op)
            OP_LOAD: begin
                reg_write_o  = 1'b1;
                result_src_o = RES_MEM;
                imm_src_o    = IMM_I;
                alu_src_o    = 1'b1;
            end
            OP_STORE: begin
                mem_write_o = 1'b1;
                imm_src_o   = IMM_S;
                alu_src_o   = 1'b1;
            end
            // the ALU compares two registers, the offset goes to the PC adder.
            OP_BRANCH: begin
                branch_o  = 1'b1;
                imm_src_o = IMM_B;
            end
            OP_JAL: begin
                reg_write_o  = 1'b1;
                jump_o       = 1'b1;
                result_src_o = RES_PC4;
                imm_src_o    = IMM_J;
                alu_src_o    = 1'b1;
            end
            OP_JALR: begin
                reg_write_o  = 1'b1;
                jump_o       = 1'b1;
                result_src_o = RES_PC4;
                imm_src_o    = IMM_I;
                alu_src_o    = 1'b1;
            end
            OP_OP_IMM: begin
                reg_write_o = 1'b1;
                imm_src_o   = IMM_I;
                alu_src_o   = 1'b1;
            end
            OP_OP: begin
                reg_write_o = 1'b1;
            end
            OP_LUI, OP_AUIPC: begin
                reg_write_o = 1'b1;
                imm_src_o   = IMM_U;
                alu_src_o   = 1'b1;
            end
            default: begin
                illegal_o = 1'b1;
            end
        endcase
    end

endmodule

// File: reg_file.sv
`include "decode_defs.svh"

module reg_file (
    input  logic               clk_i,
    input  logic               rst_n_i,

    input  logic [`REG_AW-1:0] rs1_i,
    input  logic [`REG_AW-1:0] rs2_i,
    input  logic [`REG_AW-1:0] rd_i,
    input  logic [`XLEN-1:0]   wr_data_i,
    input  logic               wr_en_i,

    output logic [`XLEN-1:0]   rd1_o,
    output logic [`XLEN-1:0]   rd2_o
);

    // x0 has no storage and always reads as zero.
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (rd_i != '0)) begin
            regs[rd_i] <= wr_data_i;
        end
    end

    // one read port, with the writeback value forwarded in the write cycle.
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] addr);
        logic [`XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_en_i && (rd_i == addr)) begin
            data = wr_data_i;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rd1_o = read_port(rs1_i);
        rd2_o = read_port(rs2_i);
    end

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timescale 1ns/1ps -f sim.f --top-module tb_decode_stage \
    -o tb_decode_stage \
    && ./obj_dir/tb_decode_stage > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0

// File: sim.f
+incdir+.
decode_pkg.sv
if_id_reg.sv
reg_file.sv
imm_extend.sv
main_decoder.sv
decode_stage.sv
tb_decode_stage.sv

// File: tb_decode_stage.sv
`include "decode_defs.svh"

module tb_decode_stage;

    timeunit 1ns;
    timeprecision 1ps;

    import decode_pkg::*;

    // the tests take about 120 cycles, so this limit leaves a wide margin.
    localparam int MAX_CYCLES = 2000;

    logic                clk_i = 1'b0;
    logic                rst_n_i;
    logic [`XLEN-1:0]    instr_f_i;
    logic [`XLEN-1:0]    pc_f_i;
    logic [`XLEN-1:0]    pc_plus_4_f_i;
    logic                stall_d_i;
    logic                flush_d_i;
    logic [`REG_AW-1:0]  rd_w_i;
    logic [`XLEN-1:0]    result_w_i;
    logic                reg_write_w_i;
    logic [`XLEN-1:0]    rd1_d_o;
    logic [`XLEN-1:0]    rd2_d_o;
    logic [`XLEN-1:0]    imm_ext_d_o;
    logic [`XLEN-1:0]    pc_d_o;
    logic [`XLEN-1:0]    pc_plus_4_d_o;
    logic [`REG_AW-1:0]  rs1_d_o;
    logic [`REG_AW-1:0]  rs2_d_o;
    logic [`REG_AW-1:0]  rd_d_o;
    logic [2:0]          funct3_d_o;
    logic [6:0]          funct7_d_o;
    result_src_t         result_src_d_o;
    logic                reg_write_d_o;
    logic                mem_write_d_o;
    logic                alu_src_d_o;
    logic                branch_d_o;
    logic                jump_d_o;
    logic                illegal_d_o;

    logic [4:0]          flags;
    logic [`XLEN-1:0]    model [`NUM_REGS];
    integer              seed = 32'h6b0352aa;
    int                  errors = 0;
    int                  cycles = 0;

    decode_stage u_dut (.*);

    // write-enables, branch, jump and illegal in one word.
    assign flags = {reg_write_d_o, mem_write_d_o, branch_d_o, jump_d_o, illegal_d_o};

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic step_cycle();
        @(posedge clk_i);
        @(negedge clk_i);
    endtask

    // load one fetch slot and wait until the stage register has taken it.
    task automatic fetch(input logic [31:0] instr, input logic [31:0] pc);
        instr_f_i     = instr;
        pc_f_i        = pc;
        pc_plus_4_f_i = pc + 32'd4;
        step_cycle();
    endtask

    task automatic write_reg(input logic [4:0] rd, input logic [31:0] data);
        rd_w_i        = rd;
        result_w_i    = data;
        reg_write_w_i = 1'b1;
        step_cycle();
        reg_write_w_i = 1'b0;
        if (rd != 5'd0) begin
            model[rd] = data;
        end
    endtask

    function automatic logic [31:0] r_word(input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'b0100000, rs2, rs1, 3'b101, 5'd1, OP_OP};
    endfunction

    function automatic logic [31:0] i_word(input logic [31:0] imm, input logic [6:0] op);
        return {imm[11:0], 5'd2, 3'b010, 5'd7, op};
    endfunction

    function automatic logic [31:0] s_word(input logic [31:0] imm);
        return {imm[11:5], 5'd9, 5'd2, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] b_word(input logic [31:0] imm);
        return {imm[12], imm[10:5], 5'd9, 5'd2, 3'b001, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_word(input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OP_JAL};
    endfunction

    function automatic logic [31:0] u_word(input logic [31:0] imm, input logic [6:0] op);
        return {imm[31:12], 5'd5, op};
    endfunction

    // expected control set is ordered {rw, mw, as, br, jp, ill}.
    task automatic decode_case(input logic [31:0] instr, input logic [31:0] pc,
                               input logic has_imm, input logic [31:0] imm,
                               input result_src_t res, input logic [5:0] ctrl);
        fetch(instr, pc);
        if (has_imm) begin
            check_value("imm_ext", imm_ext_d_o, imm);
        end
        if (!ctrl[0]) begin
            check_value("result_src", 32'(result_src_d_o), 32'(res));
            check_value("alu_src", 32'(alu_src_d_o), 32'(ctrl[3]));
        end
        check_value("flags", 32'(flags), 32'({ctrl[5:4], ctrl[2:0]}));
        check_value("rd", 32'(rd_d_o), 32'(instr[11:7]));
        check_value("rs1", 32'(rs1_d_o), 32'(instr[19:15]));
        check_value("rs2", 32'(rs2_d_o), 32'(instr[24:20]));
        check_value("funct3", 32'(funct3_d_o), 32'(instr[14:12]));
        check_value("funct7", 32'(funct7_d_o), 32'(instr[31:25]));
        check_value("pc", pc_d_o, pc);
        check_value("pc_plus_4", pc_plus_4_d_o, pc + 32'd4);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic verify_reset_state();
        check_value("bubble flags", 32'(flags), 32'(5'b00001));
        check_value("bubble pc", pc_d_o, 32'd0);
        for (int i = 0; i < `NUM_REGS; i++) begin
            fetch(r_word(5'(i), 5'(i)), 32'd0);
            check_value("reset read rs1", rd1_d_o, 32'd0);
            check_value("reset read rs2", rd2_d_o, 32'd0);
        end
    endtask

    task automatic exercise_register_file();
        for (int i = 1; i < `NUM_REGS; i++) begin
            write_reg(5'(i), $random(seed));
        end
        for (int i = 1; i < `NUM_REGS; i++) begin
            fetch(r_word(5'(i), 5'(`NUM_REGS - i)), 32'h40);
            check_value("rd1", rd1_d_o, model[i]);
            check_value("rd2", rd2_d_o, model[`NUM_REGS - i]);
        end
        write_reg(5'd0, 32'hdead_beef);
        fetch(r_word(5'd0, 5'd0), 32'h44);
        check_value("x0 read", rd1_d_o, 32'd0);
        // a read in the write cycle sees the new value through the bypass.
        fetch(r_word(5'd5, 5'd6), 32'h48);
        rd_w_i        = 5'd5;
        result_w_i    = 32'h0bad_f00d;
        reg_write_w_i = 1'b1;
        #2;
        check_value("bypass rd1", rd1_d_o, 32'h0bad_f00d);
        check_value("bypass rd2", rd2_d_o, model[6]);
        step_cycle();
        reg_write_w_i = 1'b0;
        model[5] = 32'h0bad_f00d;
    endtask

    task automatic opcode_table();
        decode_case(i_word(-12, OP_LOAD), 32'h100, 1'b1, -12, RES_MEM, 6'b101000);
        decode_case(s_word(-300), 32'h104, 1'b1, -300, RES_ALU, 6'b011000);
        decode_case(b_word(-16), 32'h108, 1'b1, -16, RES_ALU, 6'b000100);
        decode_case(j_word(32'h7a5c4), 32'h10c, 1'b1, 32'h7a5c4, RES_PC4, 6'b101010);
        decode_case(i_word(2047, OP_JALR), 32'h110, 1'b1, 2047, RES_PC4, 6'b101010);
        decode_case(i_word(-1, OP_OP_IMM), 32'h114, 1'b1, -1, RES_ALU, 6'b101000);
        decode_case(r_word(5'd8, 5'd9), 32'h118, 1'b0, '0, RES_ALU, 6'b100000);
        decode_case(u_word(32'habcde000, OP_LUI), 32'h11c, 1'b1, 32'habcde000,
                    RES_ALU, 6'b101000);
        decode_case(u_word(32'h12345000, OP_AUIPC), 32'h120, 1'b1, 32'h12345000,
                    RES_ALU, 6'b101000);
        // custom-0 opcode is outside RV32I.
        decode_case({25'h1abcdef, 7'b0001011}, 32'h124, 1'b0, '0, RES_ALU, 6'b000001);
    endtask

    task automatic stall_and_flush();
        fetch(i_word(100, OP_OP_IMM), 32'h200);
        stall_d_i = 1'b1;
        fetch(b_word(-16), 32'h300);
        check_value("stalled pc", pc_d_o, 32'h200);
        check_value("stalled rd", 32'(rd_d_o), 32'd7);
        check_value("stalled imm", imm_ext_d_o, 32'd100);
        check_value("stalled flags", 32'(flags), 32'(5'b10000));
        // flush wins over a stall that is still high.
        flush_d_i = 1'b1;
        fetch(j_word(32'h7a5c4), 32'h400);
        stall_d_i = 1'b0;
        flush_d_i = 1'b0;
        check_value("flushed pc", pc_d_o, 32'd0);
        check_value("flushed pc_plus_4", pc_plus_4_d_o, 32'd0);
        check_value("flushed flags", 32'(flags), 32'(5'b00001));
    endtask

    initial begin
        rst_n_i       = 1'b0;
        instr_f_i     = '0;
        pc_f_i        = '0;
        pc_plus_4_f_i = '0;
        stall_d_i     = 1'b0;
        flush_d_i     = 1'b0;
        rd_w_i        = '0;
        result_w_i    = '0;
        reg_write_w_i = 1'b0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model[i] = '0;
        end
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        verify_reset_state();
        exercise_register_file();
        opcode_table();
        stall_and_flush();

        $display("checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
